// ==== Makefile ====
TB_TOP = tb_csi_bridge

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f csi_bridge_top.f --top-module csi_bridge_top

sim:
	verilator --binary --timing --assert -f csi_bridge_top.f --top-module $(TB_TOP) -o $(TB_TOP)
	@out="$$(./obj_dir/$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf obj_dir

// ==== csi_bridge_top.f ====
source/csi_bridge_pkg.sv
source/axil_reg_slave.sv
source/csi_lane_align.sv
source/csi_pattern_source.sv
source/frame_monitor.sv
source/backlight_pwm.sv
source/csi_bridge_top.sv
tests/tb_csi_bridge.sv

// ==== source/axil_reg_slave.sv ====
`timescale 1ns/100ps

module axil_reg_slave import csi_bridge_pkg::*; (
	input  logic                   w_csi_rx_clk,
	input  logic                   w_sys_rstn,

	// Write address, data and response
	input  logic [AXI_ADDR_W-1:0]  awaddr_i,
	input  logic                   awvalid_i,
	output logic                   awready_o,
	input  logic [AXI_DATA_W-1:0]  wdata_i,
	input  logic                   wvalid_i,
	output logic                   wready_o,
	output resp_t                  bresp_o,
	output logic                   bvalid_o,
	input  logic                   bready_i,

	// Read address and data
	input  logic [AXI_ADDR_W-1:0]  araddr_i,
	input  logic                   arvalid_i,
	output logic                   arready_o,
	output logic [AXI_DATA_W-1:0]  rdata_o,
	output resp_t                  rresp_o,
	output logic                   rvalid_o,
	input  logic                   rready_i,

	input  logic [FRAME_CNT_W-1:0] frame_count_i,
	output logic                   pattern_en_o,
	output logic [PWM_DUTY_W-1:0]  pwm_duty_o
);

	logic      wr_fire;
	logic      wr_ok;
	logic      rd_fire;
	logic      rd_ok;
	reg_word_u wr_word;
	reg_word_u rd_word;

	//////////////////////////////
	// Write channel
	//////////////////////////////

	// AW and W taken together, blocked while B is pending
	assign wr_fire   = awvalid_i && wvalid_i && !bvalid_o;
	assign awready_o = wr_fire;
	assign wready_o  = wr_fire;

	assign wr_word = wdata_i;
	// Only CTRL and PWM are writable
	assign wr_ok   = (awaddr_i == REG_CTRL) || (awaddr_i == REG_PWM);

	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			bvalid_o     <= 1'b0;
			pattern_en_o <= 1'b0;
			pwm_duty_o   <= '0;
		end else begin
			// Response held until master takes it
			if (wr_fire)
				bvalid_o <= 1'b1;
			else if (bready_i)
				bvalid_o <= 1'b0;

			// Same word, decoded by address
			if (wr_fire) begin
				case (awaddr_i)
					REG_CTRL: pattern_en_o <= wr_word.ctrl.pattern_en;
					REG_PWM:  pwm_duty_o   <= wr_word.pwm.duty;
					default:  ;
				endcase
			end
		end
	end

	always_ff @(posedge w_csi_rx_clk) begin
		if (wr_fire)
			bresp_o <= wr_ok ? RESP_OKAY : RESP_SLVERR;
	end

	//////////////////////////////
	// Read channel
	//////////////////////////////

	assign arready_o = !rvalid_o;
	assign rd_fire   = arvalid_i && !rvalid_o;

	// Readback mux, unmapped reads give zero
	always_comb begin
		rd_word = '0;
		rd_ok   = 1'b1;
		case (araddr_i)
			REG_CTRL:   rd_word.ctrl.pattern_en = pattern_en_o;
			REG_PWM:    rd_word.pwm.duty        = pwm_duty_o;
			REG_FRAMES: rd_word                 = AXI_DATA_W'(frame_count_i);
			default:    rd_ok                   = 1'b0;
		endcase
	end

	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn)
			rvalid_o <= 1'b0;
		else if (rd_fire)
			rvalid_o <= 1'b1;
		else if (rready_i)
			rvalid_o <= 1'b0;
	end

	// Data captured with the AR handshake
	always_ff @(posedge w_csi_rx_clk) begin
		if (rd_fire) begin
			rdata_o <= rd_word;
			rresp_o <= rd_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// Responses may not be withdrawn under back-pressure
	a_bvalid_hold: assert property (@(posedge w_csi_rx_clk) disable iff (!w_sys_rstn)
		bvalid_o && !bready_i |=> bvalid_o);
	a_rvalid_hold: assert property (@(posedge w_csi_rx_clk) disable iff (!w_sys_rstn)
		rvalid_o && !rready_i |=> rvalid_o);

endmodule

// ==== source/backlight_pwm.sv ====
`timescale 1ns/100ps

module backlight_pwm import csi_bridge_pkg::*; (
	input  logic                  w_csi_rx_clk,
	input  logic                  w_sys_rstn,
	input  logic [PWM_DUTY_W-1:0] duty_i,
	output logic                  pwm_o
);

	logic [PWM_CNT_W-1:0] pwm_cnt;
	logic [PWM_CNT_W-1:0] duty_level;

	// Duty scaled to counter range, 16 counts per step
	assign duty_level = {duty_i, {(PWM_CNT_W - PWM_DUTY_W){1'b0}}};

	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			pwm_cnt <= '0;
			pwm_o   <= 1'b0;
		end else begin
			pwm_cnt <= pwm_cnt + 1'b1;
			// Zero duty never beats the counter, backlight off
			pwm_o   <= duty_level > pwm_cnt;
		end
	end

	a_off_at_zero: assert property (@(posedge w_csi_rx_clk) disable iff (!w_sys_rstn)
		(duty_i == '0) && $past(duty_i == '0) |-> !pwm_o);

endmodule

// ==== source/csi_bridge_pkg.sv ====
package csi_bridge_pkg;

	//////////////////////////////
	// AXI4-Lite register bus
	//////////////////////////////

	localparam int AXI_ADDR_W = 4;
	localparam int AXI_DATA_W = 32;

	// Register map, word aligned
	localparam logic [AXI_ADDR_W-1:0] REG_CTRL   = 4'h0;
	localparam logic [AXI_ADDR_W-1:0] REG_PWM    = 4'h4;
	// Read only
	localparam logic [AXI_ADDR_W-1:0] REG_FRAMES = 4'h8;

	// Only the two responses this slave ever returns
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_t;

	//////////////////////////////
	// CSI lanes and video word
	//////////////////////////////

	localparam int LANE_COUNT  = 4;
	localparam int LANE_BYTE_W = 8;
	localparam int PIX_W       = LANE_COUNT * LANE_BYTE_W;

	// Board swaps p/n on D1 and D0
	localparam logic [LANE_COUNT-1:0] LANE_INVERT = 4'b0011;

	// Frame monitor and backlight
	localparam int FRAME_CNT_W = 16;
	localparam int LED_BIT     = 3;
	localparam int PWM_DUTY_W  = 8;
	localparam int PWM_CNT_W   = 12;

	// Test pattern timing, in clocks and lines
	localparam int PAT_H_ACTIVE = 16;
	localparam int PAT_H_TOTAL  = 24;
	localparam int PAT_V_ACTIVE = 4;
	localparam int PAT_V_TOTAL  = 6;
	localparam int PAT_H_CNT_W  = $clog2(PAT_H_TOTAL);
	localparam int PAT_V_CNT_W  = $clog2(PAT_V_TOTAL);

	// One bus word, seen as control or as PWM register
	typedef union packed {
		struct packed {
			logic [AXI_DATA_W-2:0] rsvd;
			logic                  pattern_en;
		} ctrl;
		struct packed {
			logic [AXI_DATA_W-PWM_DUTY_W-1:0] rsvd;
			logic [PWM_DUTY_W-1:0]            duty;
		} pwm;
	} reg_word_u;

endpackage

// ==== source/csi_bridge_top.sv ====
`timescale 1ns/100ps

module csi_bridge_top import csi_bridge_pkg::*; (
	input  logic                   w_csi_rx_clk,
	input  logic                   w_sys_rstn,

	// AXI4-Lite slave port
	input  logic [AXI_ADDR_W-1:0]  awaddr_i,
	input  logic                   awvalid_i,
	output logic                   awready_o,
	input  logic [AXI_DATA_W-1:0]  wdata_i,
	input  logic                   wvalid_i,
	output logic                   wready_o,
	output logic [1:0]             bresp_o,
	output logic                   bvalid_o,
	input  logic                   bready_i,
	input  logic [AXI_ADDR_W-1:0]  araddr_i,
	input  logic                   arvalid_i,
	output logic                   arready_o,
	output logic [AXI_DATA_W-1:0]  rdata_o,
	output logic [1:0]             rresp_o,
	output logic                   rvalid_o,
	input  logic                   rready_i,

	// CSI HS lane bytes and decoder flags
	input  logic [LANE_BYTE_W-1:0] csi_rxd0_hs_i,
	input  logic [LANE_BYTE_W-1:0] csi_rxd1_hs_i,
	input  logic [LANE_BYTE_W-1:0] csi_rxd2_hs_i,
	input  logic [LANE_BYTE_W-1:0] csi_rxd3_hs_i,
	input  logic                   csi_vsync_i,
	input  logic                   csi_hsync_i,
	input  logic                   csi_valid_i,

	// Video out
	output logic                   vid_vs_o,
	output logic                   vid_hs_o,
	output logic                   vid_de_o,
	output logic [PIX_W-1:0]       vid_data_o,

	output logic                   led_o,
	output logic                   dsi_pwm_o
);

	// Register outputs
	logic                   pattern_en;
	logic [PWM_DUTY_W-1:0]  pwm_duty;
	logic [FRAME_CNT_W-1:0] frame_count;

	// Corrected lane stream
	logic                   al_vs;
	logic                   al_hs;
	logic                   al_de;
	logic [PIX_W-1:0]       al_data;

	//////////////////////////////
	// Control registers
	//////////////////////////////

	axil_reg_slave axil_reg_slave_inst (
		.w_csi_rx_clk  (w_csi_rx_clk),
		.w_sys_rstn    (w_sys_rstn),
		.awaddr_i      (awaddr_i),
		.awvalid_i     (awvalid_i),
		.awready_o     (awready_o),
		.wdata_i       (wdata_i),
		.wvalid_i      (wvalid_i),
		.wready_o      (wready_o),
		.bresp_o       (bresp_o),
		.bvalid_o      (bvalid_o),
		.bready_i      (bready_i),
		.araddr_i      (araddr_i),
		.arvalid_i     (arvalid_i),
		.arready_o     (arready_o),
		.rdata_o       (rdata_o),
		.rresp_o       (rresp_o),
		.rvalid_o      (rvalid_o),
		.rready_i      (rready_i),
		.frame_count_i (frame_count),
		.pattern_en_o  (pattern_en),
		.pwm_duty_o    (pwm_duty)
	);

	//////////////////////////////
	// Video path
	//////////////////////////////

	// Stage 1, lane polarity and packing
	csi_lane_align csi_lane_align_inst (
		.w_csi_rx_clk (w_csi_rx_clk),
		.w_sys_rstn   (w_sys_rstn),
		.lane0_i      (csi_rxd0_hs_i),
		.lane1_i      (csi_rxd1_hs_i),
		.lane2_i      (csi_rxd2_hs_i),
		.lane3_i      (csi_rxd3_hs_i),
		.vsync_i      (csi_vsync_i),
		.hsync_i      (csi_hsync_i),
		.valid_i      (csi_valid_i),
		.vs_o         (al_vs),
		.hs_o         (al_hs),
		.de_o         (al_de),
		.data_o       (al_data)
	);

	// Stage 2, pattern or camera
	csi_pattern_source csi_pattern_source_inst (
		.w_csi_rx_clk (w_csi_rx_clk),
		.w_sys_rstn   (w_sys_rstn),
		.pattern_en_i (pattern_en),
		.rx_vs_i      (al_vs),
		.rx_hs_i      (al_hs),
		.rx_de_i      (al_de),
		.rx_data_i    (al_data),
		.vs_o         (vid_vs_o),
		.hs_o         (vid_hs_o),
		.de_o         (vid_de_o),
		.data_o       (vid_data_o)
	);

	// Counts frames on the outgoing stream
	frame_monitor frame_monitor_inst (
		.w_csi_rx_clk  (w_csi_rx_clk),
		.w_sys_rstn    (w_sys_rstn),
		.vs_i          (vid_vs_o),
		.frame_count_o (frame_count),
		.led_o         (led_o)
	);

	// LCD backlight
	backlight_pwm backlight_pwm_inst (
		.w_csi_rx_clk (w_csi_rx_clk),
		.w_sys_rstn   (w_sys_rstn),
		.duty_i       (pwm_duty),
		.pwm_o        (dsi_pwm_o)
	);

endmodule

// ==== source/csi_lane_align.sv ====
`timescale 1ns/100ps

module csi_lane_align import csi_bridge_pkg::*; (
	input  logic                   w_csi_rx_clk,
	input  logic                   w_sys_rstn,
	input  logic [LANE_BYTE_W-1:0] lane0_i,
	input  logic [LANE_BYTE_W-1:0] lane1_i,
	input  logic [LANE_BYTE_W-1:0] lane2_i,
	input  logic [LANE_BYTE_W-1:0] lane3_i,
	input  logic                   vsync_i,
	input  logic                   hsync_i,
	input  logic                   valid_i,
	output logic                   vs_o,
	output logic                   hs_o,
	output logic                   de_o,
	output logic [PIX_W-1:0]       data_o
);

	logic [LANE_BYTE_W-1:0] lane_byte [LANE_COUNT];
	logic [PIX_W-1:0]       fixed_word;

	assign lane_byte[0] = lane0_i;
	assign lane_byte[1] = lane1_i;
	assign lane_byte[2] = lane2_i;
	assign lane_byte[3] = lane3_i;

	// Undo swapped p/n pairs, lane i lands in byte i
	always_comb begin
		for (int i = 0; i < LANE_COUNT; i++) begin
			fixed_word[i*LANE_BYTE_W +: LANE_BYTE_W] =
				lane_byte[i] ^ {LANE_BYTE_W{LANE_INVERT[i]}};
		end
	end

	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			vs_o <= 1'b0;
			hs_o <= 1'b0;
			de_o <= 1'b0;
		end else begin
			vs_o <= vsync_i;
			hs_o <= hsync_i;
			// Pixel only counts inside the line
			de_o <= hsync_i && valid_i;
		end
	end

	always_ff @(posedge w_csi_rx_clk) begin
		data_o <= fixed_word;
	end

endmodule

// ==== source/csi_pattern_source.sv ====
`timescale 1ns/100ps

module csi_pattern_source import csi_bridge_pkg::*; (
	input  logic             w_csi_rx_clk,
	input  logic             w_sys_rstn,
	input  logic             pattern_en_i,
	input  logic             rx_vs_i,
	input  logic             rx_hs_i,
	input  logic             rx_de_i,
	input  logic [PIX_W-1:0] rx_data_i,
	output logic             vs_o,
	output logic             hs_o,
	output logic             de_o,
	output logic [PIX_W-1:0] data_o
);

	logic [PAT_H_CNT_W-1:0] pix_cnt;
	logic [PAT_V_CNT_W-1:0] line_cnt;
	logic                   pat_vs;
	logic                   pat_hs;
	logic [PIX_W-1:0]       pat_data;

	//////////////////////////////
	// Pattern timing
	//////////////////////////////

	// Held at origin while disabled, so a new run starts at line 0 pixel 0
	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			pix_cnt  <= '0;
			line_cnt <= '0;
		end else if (!pattern_en_i) begin
			pix_cnt  <= '0;
			line_cnt <= '0;
		end else if (pix_cnt == PAT_H_CNT_W'(PAT_H_TOTAL - 1)) begin
			pix_cnt <= '0;
			// End of frame wraps to line 0
			if (line_cnt == PAT_V_CNT_W'(PAT_V_TOTAL - 1))
				line_cnt <= '0;
			else
				line_cnt <= line_cnt + 1'b1;
		end else begin
			pix_cnt <= pix_cnt + 1'b1;
		end
	end

	// Active window
	assign pat_vs   = line_cnt < PAT_V_CNT_W'(PAT_V_ACTIVE);
	assign pat_hs   = pat_vs && (pix_cnt < PAT_H_CNT_W'(PAT_H_ACTIVE));
	// Ramp, pixel index within the line
	assign pat_data = PIX_W'(pix_cnt);

	//////////////////////////////
	// Output select
	//////////////////////////////

	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			vs_o <= 1'b0;
			hs_o <= 1'b0;
			de_o <= 1'b0;
		end else if (pattern_en_i) begin
			vs_o <= pat_vs;
			hs_o <= pat_hs;
			// de and hs coincide in the pattern
			de_o <= pat_hs;
		end else begin
			vs_o <= rx_vs_i;
			hs_o <= rx_hs_i;
			de_o <= rx_de_i;
		end
	end

	always_ff @(posedge w_csi_rx_clk) begin
		data_o <= pattern_en_i ? pat_data : rx_data_i;
	end

	// Holds for both sources, the camera one via the aligner
	a_de_in_line: assert property (@(posedge w_csi_rx_clk) disable iff (!w_sys_rstn)
		de_o |-> hs_o);

endmodule

// ==== source/frame_monitor.sv ====
`timescale 1ns/100ps

module frame_monitor import csi_bridge_pkg::*; (
	input  logic                   w_csi_rx_clk,
	input  logic                   w_sys_rstn,
	input  logic                   vs_i,
	output logic [FRAME_CNT_W-1:0] frame_count_o,
	output logic                   led_o
);

	logic vs_q;
	logic frame_start;

	// Rising vsync marks a new frame
	assign frame_start = vs_i && !vs_q;

	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			vs_q          <= 1'b0;
			frame_count_o <= '0;
		end else begin
			vs_q <= vs_i;
			// Wraps on overflow
			if (frame_start)
				frame_count_o <= frame_count_o + 1'b1;
		end
	end

	// Toggles every 8 frames
	assign led_o = frame_count_o[LED_BIT];

endmodule

// ==== tests/tb_csi_bridge.sv ====
`timescale 1ns/100ps

module tb_csi_bridge import csi_bridge_pkg::*; ();

	localparam int WAIT_LIMIT  = 32;
	localparam int FRAME_CLKS  = PAT_V_TOTAL * PAT_H_TOTAL;
	localparam int LANE_CYCLES = 300;

	logic                   w_csi_rx_clk;
	logic                   w_sys_rstn;
	logic [AXI_ADDR_W-1:0]  awaddr;
	logic                   awvalid;
	logic                   awready;
	logic [AXI_DATA_W-1:0]  wdata;
	logic                   wvalid;
	logic                   wready;
	logic [1:0]             bresp;
	logic                   bvalid;
	logic                   bready;
	logic [AXI_ADDR_W-1:0]  araddr;
	logic                   arvalid;
	logic                   arready;
	logic [AXI_DATA_W-1:0]  rdata;
	logic [1:0]             rresp;
	logic                   rvalid;
	logic                   rready;
	logic [LANE_BYTE_W-1:0] csi_rxd0_hs;
	logic [LANE_BYTE_W-1:0] csi_rxd1_hs;
	logic [LANE_BYTE_W-1:0] csi_rxd2_hs;
	logic [LANE_BYTE_W-1:0] csi_rxd3_hs;
	logic                   csi_vsync;
	logic                   csi_hsync;
	logic                   csi_valid;
	logic                   vid_vs;
	logic                   vid_hs;
	logic                   vid_de;
	logic [PIX_W-1:0]       vid_data;
	logic                   led;
	logic                   dsi_pwm;

	int          errors = 0;
	integer      seed = 67774;
	// Expected lane word and flags, two stages deep like the DUT
	logic [31:0] exp_d1;
	logic [31:0] exp_d2;
	// Flags as vs, hs, de
	logic [2:0]  flags_d1;
	logic [2:0]  flags_d2;
	logic        lane_chk = 1'b0;
	logic        chk_d1 = 1'b0;
	logic        chk_d2 = 1'b0;
	// Rising edges of vid_vs seen by the testbench
	logic        vs_prev = 1'b0;
	logic [31:0] vs_edges = '0;

	csi_bridge_top csi_bridge_top_inst (
		.w_csi_rx_clk (w_csi_rx_clk), .w_sys_rstn (w_sys_rstn),
		.awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready),
		.wdata_i (wdata), .wvalid_i (wvalid), .wready_o (wready),
		.bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready),
		.araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
		.rdata_o (rdata), .rresp_o (rresp), .rvalid_o (rvalid), .rready_i (rready),
		.csi_rxd0_hs_i (csi_rxd0_hs), .csi_rxd1_hs_i (csi_rxd1_hs),
		.csi_rxd2_hs_i (csi_rxd2_hs), .csi_rxd3_hs_i (csi_rxd3_hs),
		.csi_vsync_i (csi_vsync), .csi_hsync_i (csi_hsync), .csi_valid_i (csi_valid),
		.vid_vs_o (vid_vs), .vid_hs_o (vid_hs), .vid_de_o (vid_de),
		.vid_data_o (vid_data), .led_o (led), .dsi_pwm_o (dsi_pwm)
	);

	always #50 w_csi_rx_clk = ~w_csi_rx_clk;

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// Inverted lanes flipped back, lane i in byte i
	function automatic logic [31:0] expected_pixel(input logic [7:0] b0,
		input logic [7:0] b1, input logic [7:0] b2, input logic [7:0] b3);
		logic [LANE_BYTE_W-1:0] lane [LANE_COUNT];
		logic [31:0]            word;
		lane[0] = b0;
		lane[1] = b1;
		lane[2] = b2;
		lane[3] = b3;
		for (int i = 0; i < LANE_COUNT; i++)
			word[i*LANE_BYTE_W +: LANE_BYTE_W] = LANE_INVERT[i] ? ~lane[i] : lane[i];
		return word;
	endfunction

	// Full-word write, B held back for hold cycles
	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
		input logic [1:0] exp_resp, input int hold);
		int n;
		int taken;
		@(negedge w_csi_rx_clk);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		n     = 0;
		taken = 0;
		do begin
			@(posedge w_csi_rx_clk);
			// Ready still shows the state before this edge
			if (awready && wready)
				taken++;
			@(negedge w_csi_rx_clk);
			n++;
		end while (!bvalid && n < WAIT_LIMIT);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		if (!bvalid) begin
			$display("ERROR: write to address %h got no response", addr);
			errors++;
			return;
		end
		check_value(32'(taken), 32'd1, "AW and W handshakes per write");
		check_value(32'(bresp), 32'(exp_resp), "write response");
		repeat (hold) begin
			@(negedge w_csi_rx_clk);
			check_value(32'(bvalid), 32'd1, "bvalid held while bready low");
		end
		bready = 1'b1;
		n = 0;
		do begin
			@(negedge w_csi_rx_clk);
			n++;
		end while (bvalid && n < WAIT_LIMIT);
		bready = 1'b0;
		if (bvalid) begin
			$display("ERROR: bvalid stayed high after bready");
			errors++;
		end
	endtask

	task automatic read_and_check(input logic [3:0] addr, input logic [31:0] exp_data,
		input logic [1:0] exp_resp, input string what);
		int n;
		int taken;
		@(negedge w_csi_rx_clk);
		araddr  = addr;
		arvalid = 1'b1;
		n     = 0;
		taken = 0;
		do begin
			@(posedge w_csi_rx_clk);
			if (arready)
				taken++;
			@(negedge w_csi_rx_clk);
			n++;
		end while (!rvalid && n < WAIT_LIMIT);
		arvalid = 1'b0;
		if (!rvalid) begin
			$display("ERROR: read of address %h got no response", addr);
			errors++;
			return;
		end
		check_value(32'(taken), 32'd1, "AR handshakes per read");
		// No new address taken while R is pending
		check_value(32'(arready), 32'd0, "arready while R pending");
		check_value(rdata, exp_data, what);
		check_value(32'(rresp), 32'(exp_resp), "read response");
		rready = 1'b1;
		n = 0;
		do begin
			@(negedge w_csi_rx_clk);
			n++;
		end while (rvalid && n < WAIT_LIMIT);
		rready = 1'b0;
		if (rvalid) begin
			$display("ERROR: rvalid stayed high after rready");
			errors++;
		end
	endtask

	// One whole pattern frame, from the next vs rise
	task automatic check_pattern_frame();
		int n;
		int de_run;
		int lines;
		n = 0;
		while (vid_vs && n < 2 * FRAME_CLKS) begin
			@(negedge w_csi_rx_clk);
			n++;
		end
		while (!vid_vs && n < 2 * FRAME_CLKS) begin
			@(negedge w_csi_rx_clk);
			n++;
		end
		if (!vid_vs) begin
			$display("ERROR: no pattern frame start seen");
			errors++;
			return;
		end
		de_run = 0;
		lines  = 0;
		repeat (FRAME_CLKS) begin
			// Pattern hs and de cover the same pixels
			check_value(32'(vid_hs), 32'(vid_de), "pattern hs against de");
			if (vid_de) begin
				check_value(vid_data, 32'(de_run), "pattern pixel value");
				de_run++;
			end else if (de_run != 0) begin
				check_value(32'(de_run), PAT_H_ACTIVE, "de cycles in pattern line");
				lines++;
				de_run = 0;
			end
			@(negedge w_csi_rx_clk);
		end
		check_value(32'(lines), PAT_V_ACTIVE, "active lines per pattern frame");
	endtask

	//////////////////////////////
	// Lane path checker
	//////////////////////////////

	always @(posedge w_csi_rx_clk) begin
		exp_d1   <= expected_pixel(csi_rxd0_hs, csi_rxd1_hs, csi_rxd2_hs, csi_rxd3_hs);
		exp_d2   <= exp_d1;
		flags_d1 <= {csi_vsync, csi_hsync, csi_hsync && csi_valid};
		flags_d2 <= flags_d1;
		chk_d1   <= lane_chk;
		chk_d2   <= chk_d1;
	end

	// Outputs settle after the rising edge
	always @(negedge w_csi_rx_clk) begin
		if (chk_d2) begin
			check_value(vid_data, exp_d2, "lane word");
			check_value(32'({vid_vs, vid_hs, vid_de}), 32'(flags_d2), "lane vs, hs and de");
		end
	end

	always @(negedge w_csi_rx_clk) begin
		vs_prev <= vid_vs;
		if (w_sys_rstn && vid_vs && !vs_prev)
			vs_edges <= vs_edges + 1;
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int duties [4];
		int high_cnt;
		duties = '{0, 1, 128, 255};
		w_csi_rx_clk = 1'b0;
		w_sys_rstn   = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		csi_rxd0_hs = '0;
		csi_rxd1_hs = '0;
		csi_rxd2_hs = '0;
		csi_rxd3_hs = '0;
		csi_vsync = 1'b0;
		csi_hsync = 1'b0;
		csi_valid = 1'b0;
		repeat (10) @(negedge w_csi_rx_clk);
		w_sys_rstn = 1'b1;

		// Reset state
		@(negedge w_csi_rx_clk);
		check_value(32'({dsi_pwm, led, vid_vs, vid_hs, vid_de}), 32'd0, "outputs after reset");
		read_and_check(REG_CTRL, 32'd0, RESP_OKAY, "CTRL after reset");
		read_and_check(REG_PWM, 32'd0, RESP_OKAY, "PWM after reset");
		read_and_check(REG_FRAMES, 32'd0, RESP_OKAY, "FRAMES after reset");

		// Register access and error responses
		write_reg(REG_CTRL, 32'hFFFF_FFFE, RESP_OKAY, 0);
		read_and_check(REG_CTRL, 32'd0, RESP_OKAY, "CTRL with bit 0 clear");
		write_reg(REG_PWM, 32'hABCD_12C3, RESP_OKAY, 0);
		read_and_check(REG_PWM, 32'h0000_00C3, RESP_OKAY, "PWM duty field");
		write_reg(4'hC, 32'hFFFF_FFFF, RESP_SLVERR, 0);
		write_reg(REG_FRAMES, 32'h0000_1234, RESP_SLVERR, 0);
		read_and_check(REG_CTRL, 32'd0, RESP_OKAY, "CTRL after bad writes");
		read_and_check(REG_PWM, 32'h0000_00C3, RESP_OKAY, "PWM after bad writes");
		read_and_check(REG_FRAMES, 32'd0, RESP_OKAY, "FRAMES after write attempt");
		read_and_check(4'hC, 32'd0, RESP_SLVERR, "unmapped read data");
		write_reg(REG_PWM, 32'h0000_005A, RESP_OKAY, 5);
		read_and_check(REG_PWM, 32'h0000_005A, RESP_OKAY, "PWM after held response");

		// Camera stream through lane correction
		lane_chk = 1'b1;
		repeat (LANE_CYCLES) begin
			csi_rxd0_hs = 8'($random(seed));
			csi_rxd1_hs = 8'($random(seed));
			csi_rxd2_hs = 8'($random(seed));
			csi_rxd3_hs = 8'($random(seed));
			csi_vsync   = 1'($random(seed));
			csi_hsync   = 1'($random(seed));
			csi_valid   = 1'($random(seed));
			@(negedge w_csi_rx_clk);
		end
		lane_chk  = 1'b0;
		csi_vsync = 1'b0;
		csi_hsync = 1'b0;
		csi_valid = 1'b0;

		// Test pattern, two frames
		write_reg(REG_CTRL, 32'hFFFF_FFFF, RESP_OKAY, 0);
		read_and_check(REG_CTRL, 32'h0000_0001, RESP_OKAY, "CTRL with bit 0 set");
		check_pattern_frame();
		check_pattern_frame();
		write_reg(REG_CTRL, 32'h0000_0000, RESP_OKAY, 0);

		// Frame count once the stream is quiet
		repeat (8) @(negedge w_csi_rx_clk);
		read_and_check(REG_FRAMES, {16'h0, vs_edges[15:0]}, RESP_OKAY, "frame count");
		check_value(32'(led), 32'(vs_edges[LED_BIT]), "LED from frame count");

		// Backlight, one full counter period per duty
		foreach (duties[i]) begin
			write_reg(REG_PWM, 32'(duties[i]), RESP_OKAY, 0);
			repeat (4) @(negedge w_csi_rx_clk);
			high_cnt = 0;
			repeat (1 << PWM_CNT_W) begin
				if (dsi_pwm)
					high_cnt++;
				@(negedge w_csi_rx_clk);
			end
			check_value(32'(high_cnt), 32'(16 * duties[i]), "PWM high cycles");
		end

		$display("Simulation finished with %0d errors", errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule
